//--- Bender.yml
package:
  name: spu_lane

sources:
  - spu_pkg.sv
  - spu_op_nop.sv
  - spu_op_sel.sv
  - spu_op_alu.sv
  - spu_lane.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spu_lane.sv

//--- sim.f
+incdir+.
spu_pkg.sv
spu_op_nop.sv
spu_op_sel.sv
spu_op_alu.sv
spu_lane.sv
tb_spu_lane.sv

//--- spu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module spu_lane
        #(
            parameter   int                     N           = 4,
            parameter   int                     DATA_BITS   = 16,
            parameter   int                     SEL_LATENCY = 1,
            parameter   int                     ALU_LATENCY = 2,
            parameter   int                     OUT_LATENCY = 1,
            parameter   logic [DATA_BITS-1:0]   CLEAR_DATA  = '0,
            localparam  int                     SEL_BITS    = (N > 1) ? $clog2(N) : 1
        )
        (
            input   var logic                           reset,
            input   var logic                           clk,
            input   var logic                           cke,

            input   var logic [N-1:0][DATA_BITS-1:0]    s_data,
            input   var logic [SEL_BITS-1:0]            s_sel_a,
            input   var logic [SEL_BITS-1:0]            s_sel_b,
            input   var spu_pkg::spu_ctrl_t             s_ctrl,

            output  var logic [DATA_BITS-1:0]           m_data,
            output  var logic                           m_valid
        );

    logic [DATA_BITS-1:0]               sel_a_data;
    logic [DATA_BITS-1:0]               sel_b_data;
    logic [spu_pkg::SPU_OPCODE_BITS-1:0] opcode_dly;
    logic                               op_clear;     // control aligned with operands
    logic                               op_valid;
    logic [DATA_BITS-1:0]               alu_data;
    logic                               alu_valid;

    spu_op_sel
            #(
                .LATENCY    (SEL_LATENCY),
                .N          (N),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_sel_a
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),
                .s_sel      (s_sel_a),
                .s_data     (s_data),
                .s_clear    (s_ctrl.clear),
                .s_valid    (s_ctrl.valid),
                .m_data     (sel_a_data),
                .m_valid    ()
            );

    spu_op_sel
            #(
                .LATENCY    (SEL_LATENCY),
                .N          (N),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_sel_b
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),
                .s_sel      (s_sel_b),
                .s_data     (s_data),
                .s_clear    (s_ctrl.clear),
                .s_valid    (s_ctrl.valid),
                .m_data     (sel_b_data),
                .m_valid    ()
            );

    // opcode, clear and valid walk beside the selectors
    spu_op_nop
            #(
                .LATENCY    (SEL_LATENCY),
                .DATA_BITS  (spu_pkg::SPU_OPCODE_BITS),
                .CLEAR_DATA ('0)
            )
        u_opcode_delay
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),
                .s_data     (s_ctrl.opcode),
                .s_clear    (s_ctrl.clear),
                .s_valid    (s_ctrl.valid),
                .m_data     (opcode_dly),
                .m_clear    (op_clear),
                .m_valid    (op_valid)
            );

    spu_op_alu
            #(
                .LATENCY    (ALU_LATENCY),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_alu
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),
                .s_opcode   (spu_pkg::spu_opcode_e'(opcode_dly)),
                .s_a        (sel_a_data),
                .s_b        (sel_b_data),
                .s_clear    (op_clear),
                .s_valid    (op_valid),
                .m_data     (alu_data),
                .m_valid    (alu_valid)
            );

    // cleared items already hold CLEAR_DATA here
    spu_op_nop
            #(
                .LATENCY    (OUT_LATENCY),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_out_delay
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),
                .s_data     (alu_data),
                .s_clear    (1'b0),
                .s_valid    (alu_valid),
                .m_data     (m_data),
                .m_clear    (),
                .m_valid    (m_valid)
            );

endmodule

`default_nettype wire

//--- spu_op_alu.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_alu
        #(
            parameter   int                     LATENCY    = 2,
            parameter   int                     DATA_BITS  = 16,
            parameter   logic [DATA_BITS-1:0]   CLEAR_DATA = '0
        )
        (
            input   var logic                   reset,
            input   var logic                   clk,
            input   var logic                   cke,

            input   var spu_pkg::spu_opcode_e   s_opcode,
            input   var logic [DATA_BITS-1:0]   s_a,
            input   var logic [DATA_BITS-1:0]   s_b,
            input   var logic                   s_clear,
            input   var logic                   s_valid,

            output  var logic [DATA_BITS-1:0]   m_data,
            output  var logic                   m_valid
        );

    logic [DATA_BITS-1:0] result;

    // all arithmetic wraps at DATA_BITS
    always_comb begin
        case (s_opcode)
            spu_pkg::OP_ADD:    result = s_a + s_b;
            spu_pkg::OP_SUB:    result = s_a - s_b;
            spu_pkg::OP_AND:    result = s_a & s_b;
            spu_pkg::OP_OR:     result = s_a | s_b;
            spu_pkg::OP_XOR:    result = s_a ^ s_b;
            spu_pkg::OP_PASS_A: result = s_a;
            spu_pkg::OP_MIN:    result = (s_a < s_b) ? s_a : s_b;  // operands are unsigned
            default:            result = '0;                       // unused code
        endcase
    end

    spu_op_nop
            #(
                .LATENCY    (LATENCY),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_delay
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),

                .s_data     (result),
                .s_clear    (s_clear),
                .s_valid    (s_valid),

                .m_data     (m_data),
                .m_clear    (),
                .m_valid    (m_valid)
            );

    // the opcode arrives through its own delay line, so check it at the operator
    a_opcode_legal: assert property (
        @(posedge clk) disable iff (reset)
        (cke && s_valid) |->
            !$isunknown(s_opcode) &&
            (s_opcode inside {spu_pkg::OP_ADD, spu_pkg::OP_SUB, spu_pkg::OP_AND,
                              spu_pkg::OP_OR, spu_pkg::OP_XOR, spu_pkg::OP_PASS_A,
                              spu_pkg::OP_MIN})
    ) else $error("illegal opcode %0h", s_opcode);

endmodule

`default_nettype wire

//--- spu_op_nop.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_nop
        #(
            parameter   int                     LATENCY    = 1,     // enabled edges of delay
            parameter   int                     DATA_BITS  = 16,
            parameter   logic [DATA_BITS-1:0]   CLEAR_DATA = '0     // m_data when clear is set
        )
        (
            input   var logic                   reset,   // sync, active high
            input   var logic                   clk,
            input   var logic                   cke,     // freezes the line when low

            input   var logic [DATA_BITS-1:0]   s_data,
            input   var logic                   s_clear,
            input   var logic                   s_valid,

            output  var logic [DATA_BITS-1:0]   m_data,
            output  var logic                   m_clear,
            output  var logic                   m_valid
        );

    // one item as it moves through the line
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 clear;
        logic                 valid;
    } stage_t;

    stage_t in_stage;
    stage_t out_stage;

    assign in_stage = '{data: s_data, clear: s_clear, valid: s_valid};

    generate
        if (LATENCY == 0) begin : g_bypass
            assign out_stage = in_stage;    // purely combinational
        end else begin : g_pipe
            stage_t pipe [LATENCY];

            always_ff @(posedge clk) begin
                if (reset) begin
                    for (int i = 0; i < LATENCY; i++) begin
                        pipe[i] <= '{data: CLEAR_DATA, clear: 1'b0, valid: 1'b0};
                    end
                end else if (cke) begin
                    pipe[0] <= in_stage;
                    for (int i = 1; i < LATENCY; i++) begin
                        pipe[i] <= pipe[i-1];   // shift one stage
                    end
                end
            end

            assign out_stage = pipe[LATENCY-1];

            // reset must flush every item in flight, not just the last stage
            a_valid_after_reset: assert property (
                @(posedge clk) reset |=> !m_valid
            ) else $error("m_valid high after reset");
        end
    endgenerate

    // clear is applied only as the item leaves
    assign m_data  = out_stage.clear ? CLEAR_DATA : out_stage.data;
    assign m_clear = out_stage.clear;
    assign m_valid = out_stage.valid;

    a_latency_range: assert property (
        @(posedge clk) LATENCY >= 0 && LATENCY <= spu_pkg::SPU_MAX_LATENCY
    ) else $error("LATENCY out of range");

endmodule

`default_nettype wire

//--- spu_op_sel.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_sel
        #(
            parameter   int                     LATENCY    = 1,
            parameter   int                     N          = 4,     // words in the bank
            parameter   int                     DATA_BITS  = 16,
            parameter   logic [DATA_BITS-1:0]   CLEAR_DATA = '0,
            localparam  int                     SEL_BITS   = (N > 1) ? $clog2(N) : 1
        )
        (
            input   var logic                           reset,
            input   var logic                           clk,
            input   var logic                           cke,

            input   var logic [SEL_BITS-1:0]            s_sel,   // word index
            input   var logic [N-1:0][DATA_BITS-1:0]    s_data,  // operand bank
            input   var logic                           s_clear,
            input   var logic                           s_valid,

            output  var logic [DATA_BITS-1:0]           m_data,
            output  var logic                           m_valid
        );

    logic [DATA_BITS-1:0] pick_data;

    assign pick_data = s_data[s_sel];   // mux is the whole operator

    // balance to LATENCY
    spu_op_nop
            #(
                .LATENCY    (LATENCY),
                .DATA_BITS  (DATA_BITS),
                .CLEAR_DATA (CLEAR_DATA)
            )
        u_delay
            (
                .reset      (reset),
                .clk        (clk),
                .cke        (cke),

                .s_data     (pick_data),
                .s_clear    (s_clear),
                .s_valid    (s_valid),

                .m_data     (m_data),
                .m_clear    (),
                .m_valid    (m_valid)
            );

    // an index past the bank would read a word that does not exist
    a_sel_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (cke && s_valid) |-> (s_sel < N)
    ) else $error("s_sel out of range: %0d", s_sel);

endmodule

`default_nettype wire

//--- spu_pkg.sv
package spu_pkg;

    // deepest pipeline any single stage may be configured for
    localparam int SPU_MAX_LATENCY = 8;

    localparam int SPU_OPCODE_BITS = 3;

    // operator codes for spu_op_alu
    typedef enum logic [SPU_OPCODE_BITS-1:0] {
        OP_ADD    = 3'd0,   // a + b, wraps
        OP_SUB    = 3'd1,   // a - b, wraps
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_PASS_A = 3'd5,   // result is a
        OP_MIN    = 3'd6    // unsigned minimum
    } spu_opcode_e;

    // control word that rides with each item through the lane
    typedef struct packed {
        spu_opcode_e opcode;    // [4:2]
        logic        clear;     // [1]
        logic        valid;     // [0]
    } spu_ctrl_t;

endpackage

//--- tb_spu_model.svh
// expected value of one item at the lane output
typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 valid;
} exp_item_t;

exp_item_t model_q[$];   // front is what m_data/m_valid hold now

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [DATA_BITS-1:0] alu_model(
    input spu_pkg::spu_opcode_e op,
    input logic [DATA_BITS-1:0] a,
    input logic [DATA_BITS-1:0] b
);
    logic [DATA_BITS-1:0] r;
    case (op)
        spu_pkg::OP_ADD:    r = a + b;               // wraps at DATA_BITS
        spu_pkg::OP_SUB:    r = a - b;
        spu_pkg::OP_AND:    r = a & b;
        spu_pkg::OP_OR:     r = a | b;
        spu_pkg::OP_XOR:    r = a ^ b;
        spu_pkg::OP_PASS_A: r = a;
        spu_pkg::OP_MIN:    r = (b < a) ? b : a;     // both unsigned
        default:            r = 'x;
    endcase
    return r;
endfunction

function automatic exp_item_t expect_item(input stim_entry_t e);
    exp_item_t r;
    r.valid = e.valid;   // valid passes untouched
    r.data  = e.clear ? CLEAR_DATA : alu_model(e.opcode, e.bank[e.sel_a], e.bank[e.sel_b]);
    return r;
endfunction

// pipeline right after reset holds only empty slots
function automatic void model_reset();
    model_q.delete();
    for (int i = 0; i < LAT_TOTAL; i++) begin
        model_q.push_back('{data: CLEAR_DATA, valid: 1'b0});
    end
endfunction

// one enabled edge moves every item one slot on
function automatic void model_step(input stim_entry_t e);
    model_q.push_back(expect_item(e));
    void'(model_q.pop_front());
endfunction

//--- tb_spu_lane.sv
`timescale 1ns/1ps

module tb_spu_lane;

    localparam int                   N           = 4;
    localparam int                   DATA_BITS   = 16;
    localparam int                   SEL_BITS    = 2;
    localparam int                   SEL_LATENCY = 1;
    localparam int                   ALU_LATENCY = 2;
    localparam int                   OUT_LATENCY = 1;
    localparam logic [DATA_BITS-1:0] CLEAR_DATA  = 16'hc1ea;   // nonzero so clears stand out
    localparam int                   LAT_TOTAL   = SEL_LATENCY + ALU_LATENCY + OUT_LATENCY;
    localparam int                   HAND_LEN    = 21;
    localparam int                   TABLE_LEN   = 64;
    localparam int                   DRAIN_LEN   = LAT_TOTAL + 2;
    localparam int                   CLK_PERIOD  = 8;
    localparam int                   WATCHDOG_NS =
        (TABLE_LEN + 4 * spu_pkg::SPU_MAX_LATENCY) * CLK_PERIOD * 2;

    typedef struct packed {
        logic [N-1:0][DATA_BITS-1:0] bank;
        logic [SEL_BITS-1:0]         sel_a;
        logic [SEL_BITS-1:0]         sel_b;
        spu_pkg::spu_opcode_e        opcode;
        logic                        clear;
        logic                        valid;
        logic                        cke;
    } stim_entry_t;

    `include "tb_spu_model.svh"

    logic                        clk;
    logic                        reset;
    logic                        cke;
    logic [N-1:0][DATA_BITS-1:0] s_data;
    logic [SEL_BITS-1:0]         s_sel_a;
    logic [SEL_BITS-1:0]         s_sel_b;
    spu_pkg::spu_ctrl_t          s_ctrl;
    logic [DATA_BITS-1:0]        m_data;
    logic                        m_valid;

    stim_entry_t stim_table [TABLE_LEN];
    stim_entry_t idle_entry;
    stim_entry_t cur;
    logic [31:0] rng_state;

    spu_lane #(
        .N           (N),
        .DATA_BITS   (DATA_BITS),
        .SEL_LATENCY (SEL_LATENCY),
        .ALU_LATENCY (ALU_LATENCY),
        .OUT_LATENCY (OUT_LATENCY),
        .CLEAR_DATA  (CLEAR_DATA)
    ) DUT (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (s_data),
        .s_sel_a (s_sel_a),
        .s_sel_b (s_sel_b),
        .s_ctrl  (s_ctrl),
        .m_data  (m_data),
        .m_valid (m_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic stim_entry_t build_entry(input logic [N-1:0][DATA_BITS-1:0] bank,
                                                input int sel_a, input int sel_b,
                                                input spu_pkg::spu_opcode_e op,
                                                input int clear, input int valid,
                                                input int en);
        stim_entry_t e;
        e.bank   = bank;
        e.sel_a  = SEL_BITS'(sel_a);
        e.sel_b  = SEL_BITS'(sel_b);
        e.opcode = op;
        e.clear  = (clear != 0);
        e.valid  = (valid != 0);
        e.cke    = (en != 0);
        return e;
    endfunction

    task automatic fill_table();
        logic [N-1:0][DATA_BITS-1:0] bank0;
        logic [N-1:0][DATA_BITS-1:0] bank1;
        logic [31:0]                 r;
        logic [2:0]                  op_code;
        bank0 = {16'hffff, 16'h8001, 16'h1234, 16'h00f0};
        bank1 = {16'h0001, 16'h7fff, 16'h8000, 16'h0000};
        stim_table[0]  = build_entry(bank0, 0, 1, spu_pkg::OP_ADD, 0, 0, 1);     // empty slot
        stim_table[1]  = build_entry(bank0, 2, 3, spu_pkg::OP_ADD, 0, 1, 1);     // carry lost
        stim_table[2]  = build_entry(bank0, 1, 0, spu_pkg::OP_SUB, 0, 1, 1);
        stim_table[3]  = build_entry(bank0, 0, 1, spu_pkg::OP_SUB, 0, 1, 1);     // borrow wraps
        stim_table[4]  = build_entry(bank0, 3, 1, spu_pkg::OP_AND, 0, 1, 1);
        stim_table[5]  = build_entry(bank0, 0, 2, spu_pkg::OP_OR, 0, 1, 1);
        stim_table[6]  = build_entry(bank0, 3, 3, spu_pkg::OP_XOR, 0, 1, 1);     // same word twice
        stim_table[7]  = build_entry(bank0, 3, 0, spu_pkg::OP_PASS_A, 0, 1, 1);
        stim_table[8]  = build_entry(bank0, 2, 1, spu_pkg::OP_MIN, 0, 1, 1);     // 8001 not min
        stim_table[9]  = build_entry(bank1, 3, 3, spu_pkg::OP_MIN, 0, 1, 1);
        stim_table[10] = build_entry(bank1, 1, 0, spu_pkg::OP_ADD, 1, 1, 1);     // cleared, valid
        stim_table[11] = build_entry(bank1, 2, 1, spu_pkg::OP_XOR, 1, 0, 1);
        stim_table[12] = build_entry(bank1, 1, 2, spu_pkg::OP_SUB, 0, 1, 0);     // freeze
        stim_table[13] = build_entry(bank1, 0, 3, spu_pkg::OP_OR, 0, 1, 0);
        stim_table[14] = build_entry(bank1, 3, 2, spu_pkg::OP_AND, 0, 1, 0);
        stim_table[15] = build_entry(bank1, 1, 2, spu_pkg::OP_SUB, 0, 1, 1);     // resume
        stim_table[16] = build_entry(bank1, 0, 1, spu_pkg::OP_ADD, 0, 1, 0);
        stim_table[17] = build_entry(bank1, 1, 2, spu_pkg::OP_MIN, 0, 1, 1);
        stim_table[18] = build_entry(bank0, 0, 0, spu_pkg::OP_ADD, 0, 0, 1);
        stim_table[19] = build_entry(bank0, 3, 2, spu_pkg::OP_XOR, 1, 1, 0);     // never accepted
        stim_table[20] = build_entry(bank0, 3, 3, spu_pkg::OP_SUB, 0, 1, 1);
        for (int i = HAND_LEN; i < TABLE_LEN; i++) begin
            for (int w = 0; w < N; w++) begin
                rng_state = xorshift32(rng_state);
                stim_table[i].bank[w] = rng_state[15:0];
            end
            rng_state = xorshift32(rng_state);
            r = rng_state;
            op_code = 3'(r[15:8] % 8'd7);   // legal codes only
            stim_table[i].sel_a  = r[1:0];
            stim_table[i].sel_b  = r[3:2];
            stim_table[i].opcode = spu_pkg::spu_opcode_e'(op_code);
            stim_table[i].clear  = (r[18:16] == 3'd0);
            stim_table[i].valid  = (r[21:20] != 2'b00);
            stim_table[i].cke    = (r[26:24] != 3'd0);
        end
    endtask

    task automatic drive_inputs(input stim_entry_t e);
        s_data  = e.bank;
        s_sel_a = e.sel_a;
        s_sel_b = e.sel_b;
        s_ctrl  = '{opcode: e.opcode, clear: e.clear, valid: e.valid};
        cke     = e.cke;
    endtask

    task automatic check_outputs();
        exp_item_t exp_now;
        exp_now = model_q[0];
        check_value("m_valid", 32'(m_valid), 32'(exp_now.valid));
        if (exp_now.valid) begin
            check_value("m_data", 32'(m_data), 32'(exp_now.data));
        end
    endtask

    initial begin
        rng_state  = 32'hf2ee_722c;
        reset      = 1'b1;
        idle_entry = build_entry('0, 0, 0, spu_pkg::OP_ADD, 0, 0, 1);
        drive_inputs(idle_entry);
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        model_reset();
        for (int i = 0; i < TABLE_LEN + DRAIN_LEN; i++) begin
            check_outputs();   // state left by the previous edge
            cur = (i < TABLE_LEN) ? stim_table[i] : idle_entry;
            drive_inputs(cur);
            @(posedge clk);
            if (cur.cke) begin
                model_step(cur);
            end
            @(negedge clk);
        end
        check_outputs();
        $display("all tests passed");
        $finish;
    end

endmodule
